// File: list.f
source/rdp_cfg_pkg.sv
source/rdp_types_pkg.sv
source/rdp_valid_predict.sv
source/rdp_read_fifo.sv
source/rdp_read_ctrl.sv
source/rdp_rdata_stage.sv
source/read_datapath.sv
verification/tb_clock_gen.sv
verification/read_datapath_checker.sv
verification/tb_read_datapath.sv

// File: source/rdp_cfg_pkg.sv
/*
 * Read datapath configuration: group and bus widths, FIFO depths, latency range
 */
package rdp_cfg_pkg;

	// ******************************
	// Memory and AFI bus geometry
	// ******************************

	// Read DQS groups on the interface
	localparam int NUM_DQS_GROUPS = 2;

	// DQ bits captured by one DQS group
	localparam int DQ_GROUP_WIDTH = 4;

	// Full rate with DDR capture gives two beats per AFI cycle
	localparam int NUM_TIMESLOTS = 2;

	localparam int MEM_DQ_WIDTH = NUM_DQS_GROUPS * DQ_GROUP_WIDTH;

	// The AFI read bus carries every time slot of every group
	localparam int AFI_DATA_WIDTH = NUM_TIMESLOTS * MEM_DQ_WIDTH;

	// ******************************
	// Buffering and latency
	// ******************************

	// Token FIFO for valid prediction, one token per AFI cycle
	localparam int VFIFO_DEPTH = 16;
	localparam int VFIFO_ADDR_WIDTH = $clog2(VFIFO_DEPTH);

	// Read data FIFO, sized for the reads that can be in flight
	localparam int READ_FIFO_DEPTH = 8;
	localparam int READ_FIFO_ADDR_WIDTH = $clog2(READ_FIFO_DEPTH);

	// Length of the latency shift register and width of the latency setting
	localparam int MAX_READ_LATENCY = 16;
	localparam int LATENCY_WIDTH = $clog2(MAX_READ_LATENCY);

endpackage

// File: source/rdp_rdata_stage.sv
/*
 * Read output stage: registers the FIFO heads on a pop, builds the AFI valid,
 * reorders data for the AFI and sequencer buses and keeps the underflow flag
 */
`timescale 1ns/1ps

module rdp_rdata_stage import rdp_cfg_pkg::*, rdp_types_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic pop_i,
	input  ddio_word_t head_i,
	input  logic [NUM_DQS_GROUPS-1:0] empty_i,
	output afi_read_t afi_read_o,
	output ddio_word_t phy_mux_read_fifo_q_o,
	output logic read_underflow_o
);

	// Popped data, still in group order
	ddio_word_t rdata_q;

	logic valid_q;
	logic underflow_q;

	// Data register only loads on a pop
	always_ff @(posedge pll_afi_clk)
	begin
		if (pop_i)
		begin
			rdata_q <= head_i;
		end
	end

	// ******************************
	// Valid and underflow
	// ******************************

	// Valid needs every group to hold data at the pop
	// An empty group at a pop marks a mistuned latency and sticks until reset
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			valid_q <= 1'b0;
			underflow_q <= 1'b0;
		end
		else
		begin
			valid_q <= pop_i & (&(~empty_i));
			if (pop_i && (|empty_i))
			begin
				underflow_q <= 1'b1;
			end
		end
	end

	// ******************************
	// Data reordering
	// ******************************

	// AFI wants time-slot order: all t0 nibbles in slot 0, all t1 nibbles in
	// slot 1, and within a slot group 0 is the lowest nibble
	always_comb
	begin
		afi_read_o.valid = valid_q;
		for (int g = 0; g < NUM_DQS_GROUPS; g++)
		begin
			afi_read_o.rdata[g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] = rdata_q[g].t0;
			afi_read_o.rdata[MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] = rdata_q[g].t1;
		end
	end

	// Sequencer calibrates per group, so it keeps the capture layout
	assign phy_mux_read_fifo_q_o = rdata_q;
	assign read_underflow_o = underflow_q;

endmodule

// File: source/rdp_read_ctrl.sv
/*
 * Read control: latency shift register and pop selection, plus the
 * registered per-group FIFO clear strobes from the sequencer
 */
`timescale 1ns/1ps

module rdp_read_ctrl import rdp_cfg_pkg::*, rdp_types_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic afi_rdata_en_i,
	input  seq_read_ctrl_t seq_ctrl_i,
	output logic pop_o,
	output logic [NUM_DQS_GROUPS-1:0] fifo_clear_o
);

	// Delay line for the read strobe, bit j holds the strobe from j+1 cycles ago
	logic [MAX_READ_LATENCY-1:0] latency_sr;

	// Tap index selected by the sequencer's latency setting
	logic [LATENCY_WIDTH-1:0] pop_tap;

	// Registered copy of the group clear strobes
	logic [NUM_DQS_GROUPS-1:0] fifo_clear_q;

	// ******************************
	// Latency shift register
	// ******************************

	// Every read strobe enters at bit 0 and walks up one bit per cycle
	// Back to back strobes simply sit in neighbouring bits, so several reads
	// can be in flight at once
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_sr <= '0;
		end
		else
		begin
			latency_sr <= {latency_sr[MAX_READ_LATENCY-2:0], afi_rdata_en_i};
		end
	end

	// ******************************
	// Pop selection
	// ******************************

	// A strobe in cycle n reaches bit L-1 in cycle n+L, which is the pop cycle
	// The sequencer keeps read_latency between 2 and 15 and holds it steady
	// while reads are outstanding
	assign pop_tap = seq_ctrl_i.read_latency - LATENCY_WIDTH'(1);

	// One pop serves all groups together, the FIFOs drain in lock step
	assign pop_o = latency_sr[pop_tap];

	// ******************************
	// Group FIFO clears
	// ******************************

	// The sequencer clears one group's FIFO at a time during calibration
	// Registering the strobe keeps the clear one cycle behind the request
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			fifo_clear_q <= '0;
		end
		else
		begin
			fifo_clear_q <= seq_ctrl_i.fifo_reset;
		end
	end

	assign fifo_clear_o = fifo_clear_q;

endmodule

// File: source/rdp_read_fifo.sv
/*
 * Read data FIFO for one DQS group: holds captured words until the latency pop
 */
`timescale 1ns/1ps

module rdp_read_fifo import rdp_cfg_pkg::*, rdp_types_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic capture_we_i,
	input  group_beat_t capture_i,
	input  logic pop_i,
	input  logic clear_i,
	output group_beat_t head_o,
	output logic empty_o
);

	// Captured words, indexed by the low pointer bits
	group_beat_t fifo_mem [READ_FIFO_DEPTH];

	// Pointers carry one extra wrap bit so full and empty stay distinct
	logic [READ_FIFO_ADDR_WIDTH:0] wr_ptr;
	logic [READ_FIFO_ADDR_WIDTH:0] rd_ptr;

	// A pop only counts when there is something to take
	logic pop_ok;

	assign pop_ok = pop_i && !empty_o;

	// ******************************
	// Storage
	// ******************************

	// Capture writes go straight into the buffer
	// There is no back-pressure, the capture side never waits
	always_ff @(posedge pll_afi_clk)
	begin
		if (capture_we_i)
		begin
			fifo_mem[wr_ptr[READ_FIFO_ADDR_WIDTH-1:0]] <= capture_i;
		end
	end

	// ******************************
	// Pointers
	// ******************************

	// The group clear from the sequencer restarts both pointers
	// A clear wins over a write or a pop in the same cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (clear_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (capture_we_i)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Head is the oldest word, readable the cycle after it was written
	assign head_o = fifo_mem[rd_ptr[READ_FIFO_ADDR_WIDTH-1:0]];
	assign empty_o = (wr_ptr == rd_ptr);

endmodule

// File: source/rdp_types_pkg.sv
/*
 * Read datapath bus types: capture words, sequencer controls, AFI read result
 */
package rdp_types_pkg;
	import rdp_cfg_pkg::*;

	// ******************************
	// Capture side
	// ******************************

	// One DQS group's capture word for a single AFI cycle
	// The later beat t1 sits above the earlier beat t0
	typedef struct packed {
		logic [DQ_GROUP_WIDTH-1:0] t1;
		logic [DQ_GROUP_WIDTH-1:0] t0;
	} group_beat_t;

	// Whole capture word ordered by group, then by time slot
	// Index 1 is group 1 and lands in the upper half
	typedef group_beat_t [NUM_DQS_GROUPS-1:0] ddio_word_t;

	// ******************************
	// Sequencer and AFI side
	// ******************************

	// Calibration controls from the sequencer
	// read_latency is a level, the other two fields are one-cycle strobes per group
	typedef struct packed {
		logic [LATENCY_WIDTH-1:0] read_latency;
		logic [NUM_DQS_GROUPS-1:0] inc_vfifo;
		logic [NUM_DQS_GROUPS-1:0] fifo_reset;
	} seq_read_ctrl_t;

	// Read result returned to the controller, data in time-slot order
	typedef struct packed {
		logic [AFI_DATA_WIDTH-1:0] rdata;
		logic valid;
	} afi_read_t;

endpackage

// File: source/rdp_valid_predict.sv
/*
 * Valid prediction for one DQS group: token FIFO turning read strobes into
 * capture write enables, with a write pointer the sequencer can step forward
 */
`timescale 1ns/1ps

module rdp_valid_predict import rdp_cfg_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic rdata_en_i,
	input  logic inc_vfifo_i,
	output logic capture_we_o
);

	// One token bit per entry, a set bit marks a cycle of valid capture data
	logic [VFIFO_DEPTH-1:0] token_mem;

	// Write pointer runs ahead of the read pointer by the tuned distance
	logic [VFIFO_ADDR_WIDTH-1:0] wr_ptr;
	logic [VFIFO_ADDR_WIDTH-1:0] rd_ptr;

	// Slot written this cycle and the slot passed over on an increment
	logic [VFIFO_ADDR_WIDTH-1:0] wr_addr;
	logic [VFIFO_ADDR_WIDTH-1:0] skip_addr;

	// The token lands one slot past the write pointer
	// With no increments the read pointer reaches it on the very next cycle
	assign wr_addr = wr_ptr + VFIFO_ADDR_WIDTH'(1);
	assign skip_addr = wr_ptr + VFIFO_ADDR_WIDTH'(2);

	// ******************************
	// Token write and pointers
	// ******************************

	// A token is written every cycle, a 1 for a read strobe and a 0 otherwise
	// An increment jumps the write pointer by two, which delays every later
	// token by one cycle relative to the read pointer
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			token_mem <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			token_mem[wr_addr] <= rdata_en_i;
			if (inc_vfifo_i)
			begin
				// Clear the skipped slot so an old token cannot resurface there
				token_mem[skip_addr] <= 1'b0;
				wr_ptr <= wr_ptr + VFIFO_ADDR_WIDTH'(2);
			end
			else
			begin
				wr_ptr <= wr_ptr + VFIFO_ADDR_WIDTH'(1);
			end
			// Read side walks through the entries at one per cycle
			rd_ptr <= rd_ptr + VFIFO_ADDR_WIDTH'(1);
		end
	end

	// ******************************
	// Token read
	// ******************************

	// The token under the read pointer enables the capture write this cycle
	// A strobe in cycle n therefore appears here in cycle n+1+k, with k the
	// number of increments taken since reset
	assign capture_we_o = token_mem[rd_ptr];

endmodule

// File: source/read_datapath.sv
/*
 * Read datapath top: read control, per-group valid prediction and read FIFOs,
 * and the output register stage
 */
`timescale 1ns/1ps

module read_datapath import rdp_cfg_pkg::*, rdp_types_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic afi_rdata_en_i,
	input  seq_read_ctrl_t seq_ctrl_i,
	input  ddio_word_t ddio_dq_i,
	output afi_read_t afi_read_o,
	output ddio_word_t phy_mux_read_fifo_q_o,
	output logic read_underflow_o
);

	// Predicted capture enables, one per group
	logic [NUM_DQS_GROUPS-1:0] capture_we;

	// Shared pop and per-group clears from the control block
	logic pop;
	logic [NUM_DQS_GROUPS-1:0] fifo_clear;

	// Heads and empty flags of the group FIFOs
	ddio_word_t fifo_head;
	logic [NUM_DQS_GROUPS-1:0] fifo_empty;

	// ******************************
	// Latency and clear control
	// ******************************

	rdp_read_ctrl u_read_ctrl (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_i  (afi_rdata_en_i),
		.seq_ctrl_i      (seq_ctrl_i),
		.pop_o           (pop),
		.fifo_clear_o    (fifo_clear)
	);

	// ******************************
	// Per-group capture path
	// ******************************

	// Each group tunes its own capture cycle and buffers its own slice
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : g_group
		rdp_valid_predict u_valid_predict (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.rdata_en_i      (afi_rdata_en_i),
			.inc_vfifo_i     (seq_ctrl_i.inc_vfifo[g]),
			.capture_we_o    (capture_we[g])
		);

		rdp_read_fifo u_read_fifo (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.capture_we_i    (capture_we[g]),
			.capture_i       (ddio_dq_i[g]),
			.pop_i           (pop),
			.clear_i         (fifo_clear[g]),
			.head_o          (fifo_head[g]),
			.empty_o         (fifo_empty[g])
		);
	end

	// ******************************
	// Output stage
	// ******************************

	rdp_rdata_stage u_rdata_stage (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.pop_i                 (pop),
		.head_i                (fifo_head),
		.empty_i               (fifo_empty),
		.afi_read_o            (afi_read_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o),
		.read_underflow_o      (read_underflow_o)
	);

endmodule

// File: verification/read_datapath_checker.sv
/*
 * Concurrent assertions on the read datapath valid, pop and underflow behavior
 */
`timescale 1ns/1ps

module read_datapath_checker import rdp_cfg_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic pop_i,
	input  logic [NUM_DQS_GROUPS-1:0] fifo_empty_i,
	input  logic afi_valid_i,
	input  logic read_underflow_i
);

	// Count of failed assertions over the whole run
	int assert_failures = 0;

	// Async reset clears valid well before the second sampled edge of a reset
	valid_low_in_reset: assert property (@(posedge pll_afi_clk)
		(!reset_n_afi_clk ##1 !reset_n_afi_clk) |-> !afi_valid_i)
		else
		begin
			assert_failures++;
			$error("AFI valid is high while reset is asserted");
		end

	// The underflow flag is sticky and only reset brings it down
	underflow_sticky: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		read_underflow_i |=> read_underflow_i)
		else
		begin
			assert_failures++;
			$error("read underflow flag fell while out of reset");
		end

	// A pop with data in every group returns valid data one cycle later
	pop_gives_valid: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(pop_i && (fifo_empty_i == '0)) |=> afi_valid_i)
		else
		begin
			assert_failures++;
			$error("pop with every group filled was not followed by valid");
		end

	// A pop that meets an empty group raises underflow instead of valid
	pop_on_empty: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(pop_i && (fifo_empty_i != '0)) |=> (!afi_valid_i && read_underflow_i))
		else
		begin
			assert_failures++;
			$error("pop on an empty group gave valid or left underflow low");
		end

endmodule

// File: verification/tb_clock_gen.sv
/*
 * Testbench clock of 40 ns period and active-low reset held for 5 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen
(
	input  logic reset_req_i,
	output logic pll_afi_clk_o,
	output logic reset_n_afi_clk_o
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 5;

	// Reset is held while the counter runs down, a request reloads it
	int reset_cnt = RESET_CYCLES;

	initial
	begin
		pll_afi_clk_o = 1'b0;
		forever #(HALF_PERIOD) pll_afi_clk_o = ~pll_afi_clk_o;
	end

	always @(posedge pll_afi_clk_o)
	begin
		if (reset_req_i)
		begin
			reset_cnt <= RESET_CYCLES;
		end
		else if (reset_cnt > 0)
		begin
			reset_cnt <= reset_cnt - 1;
		end
	end

	assign reset_n_afi_clk_o = (reset_cnt == 0);

endmodule

// File: verification/tb_read_datapath.sv
/*
 * Read datapath testbench with a stimulus table, random memory model,
 * scoreboard, underflow tracking and a cycle-count timeout
 */
`timescale 1ns/1ps

module tb_read_datapath import rdp_cfg_pkg::*, rdp_types_pkg::*;
();

	// Memory returns data MEM_RL_TB cycles after the strobe
	localparam int MEM_RL_TB = 6;
	localparam int RECOVERY_LATENCY = 9;
	localparam int HIST_DEPTH = 1024;
	localparam int NUM_ROWS = 4;

	// Underflow expectation is held low, left unchecked or held high
	localparam int UF_LOW = 0;
	localparam int UF_ANY = 1;
	localparam int UF_HIGH = 2;

	typedef struct packed {
		int k0;
		int k1;
		int latency;
		int num_reads;
		int gap;
		logic underflow;
	} test_row_t;

	typedef struct packed {
		int issue_cycle;
		int due_cycle;
	} read_entry_t;

	// Each row gives the group 0 and group 1 increments, L, the read count,
	// the gap between reads and whether underflow is expected
	localparam test_row_t TEST_TABLE [NUM_ROWS] = '{
		'{MEM_RL_TB-1, MEM_RL_TB-1, 9, 4, 3, 1'b0},
		'{MEM_RL_TB-1, MEM_RL_TB-1, 12, 12, 1, 1'b0},
		'{MEM_RL_TB-1, MEM_RL_TB-3, 9, 4, 2, 1'b0},
		'{MEM_RL_TB-1, MEM_RL_TB-1, 5, 2, 1, 1'b1}
	};

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	logic reset_req;
	logic rdata_en;
	seq_read_ctrl_t seq_ctrl;
	ddio_word_t ddio_dq;
	afi_read_t afi_read;
	ddio_word_t fifo_q;
	logic read_underflow;

	// Memory words by cycle, and reads waiting for their result
	ddio_word_t mem_hist [HIST_DEPTH];
	read_entry_t sb_queue [$];
	int cycle = 0;
	int timeout_cycles;
	int cur_k [NUM_DQS_GROUPS];
	int cur_latency;
	int uf_state;
	logic track_reads;
	int value_errors = 0;
	int event_errors = 0;

	tb_clock_gen u_clock_gen (
		.reset_req_i       (reset_req),
		.pll_afi_clk_o     (pll_afi_clk),
		.reset_n_afi_clk_o (reset_n_afi_clk)
	);

	read_datapath u_dut (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.afi_rdata_en_i        (rdata_en),
		.seq_ctrl_i            (seq_ctrl),
		.ddio_dq_i             (ddio_dq),
		.afi_read_o            (afi_read),
		.phy_mux_read_fifo_q_o (fifo_q),
		.read_underflow_o      (read_underflow)
	);

	bind read_datapath read_datapath_checker u_checker (
		.pll_afi_clk      (pll_afi_clk),
		.reset_n_afi_clk  (reset_n_afi_clk),
		.pop_i            (pop),
		.fifo_empty_i     (fifo_empty),
		.afi_valid_i      (afi_read_o.valid),
		.read_underflow_i (read_underflow_o)
	);

	// ******************************
	// Cycle counter and timeout
	// ******************************

	always @(posedge pll_afi_clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles)
		begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Group g captures the memory word driven in cycle n+1+k
	function automatic ddio_word_t expected_capture(input int issue_cycle);
		ddio_word_t word;
		for (int g = 0; g < NUM_DQS_GROUPS; g++)
		begin
			word[g] = mem_hist[(issue_cycle + 1 + cur_k[g]) % HIST_DEPTH][g];
		end
		return word;
	endfunction

	// On the AFI bus slot 0 holds the t0 nibbles and slot 1 the t1 nibbles,
	// with group 0 lowest in each slot
	function automatic logic [AFI_DATA_WIDTH-1:0] slot_order(input ddio_word_t word);
		return {word[1].t1, word[0].t1, word[1].t0, word[0].t0};
	endfunction

	// ******************************
	// Scoreboard
	// ******************************

	task automatic check_outputs();
		read_entry_t head;
		ddio_word_t exp_word;
		logic due_now;
		due_now = (sb_queue.size() > 0) && (sb_queue[0].due_cycle == cycle);
		if (afi_read.valid && !due_now)
		begin
			event_errors++;
			$display("unexpected valid on afi_read_o in cycle %0d with no read due", cycle);
		end
		else if (due_now)
		begin
			head = sb_queue.pop_front();
			exp_word = expected_capture(head.issue_cycle);
			if (!afi_read.valid)
			begin
				event_errors++;
				$display("no valid for the read issued in cycle %0d", head.issue_cycle);
			end
			else
			begin
				if (afi_read.rdata !== slot_order(exp_word))
				begin
					value_errors++;
					$display("mismatch afi_read_o.rdata: got 0x%h, expected 0x%h",
						afi_read.rdata, slot_order(exp_word));
				end
				if (fifo_q !== exp_word)
				begin
					value_errors++;
					$display("mismatch phy_mux_read_fifo_q_o: got 0x%h, expected 0x%h",
						fifo_q, exp_word);
				end
			end
		end
		if (uf_state != UF_ANY && read_underflow !== (uf_state == UF_HIGH))
		begin
			value_errors++;
			$display("mismatch read_underflow_o: got 0x%h, expected 0x%h",
				read_underflow, uf_state == UF_HIGH);
		end
	endtask

	// ******************************
	// Stimulus
	// ******************************

	// Checks the current cycle and then drives inputs 2 ns after the edge
	task automatic run_cycle(input logic rd_en, input logic [NUM_DQS_GROUPS-1:0] inc,
		input logic [NUM_DQS_GROUPS-1:0] clr, input logic req);
		logic [31:0] rnd;
		read_entry_t entry;
		@(posedge pll_afi_clk);
		#2;
		check_outputs();
		rnd = $urandom;
		ddio_dq = rnd[$bits(ddio_word_t)-1:0];
		mem_hist[cycle % HIST_DEPTH] = ddio_dq;
		rdata_en = rd_en;
		seq_ctrl.read_latency = LATENCY_WIDTH'(cur_latency);
		seq_ctrl.inc_vfifo = inc;
		seq_ctrl.fifo_reset = clr;
		reset_req = req;
		if (rd_en && track_reads)
		begin
			entry.issue_cycle = cycle;
			entry.due_cycle = cycle + cur_latency + 1;
			sb_queue.push_back(entry);
		end
	endtask

	task automatic apply_reset();
		uf_state = UF_ANY;
		run_cycle(1'b0, '0, '0, 1'b1);
		run_cycle(1'b0, '0, '0, 1'b0);
		while (!reset_n_afi_clk)
		begin
			run_cycle(1'b0, '0, '0, 1'b0);
		end
		uf_state = UF_LOW;
		if (afi_read.valid !== 1'b0)
		begin
			value_errors++;
			$display("mismatch afi_read_o.valid: got 0x%h, expected 0x0", afi_read.valid);
		end
	endtask

	// Issues reads spaced by gap and idles long enough for the last one to return
	task automatic issue_reads(input int num_reads, input int gap);
		for (int r = 0; r < num_reads; r++)
		begin
			run_cycle(1'b1, '0, '0, 1'b0);
			repeat (gap - 1) run_cycle(1'b0, '0, '0, 1'b0);
		end
		repeat (cur_latency + 3) run_cycle(1'b0, '0, '0, 1'b0);
	endtask

	task automatic run_row(input test_row_t row);
		logic [NUM_DQS_GROUPS-1:0] inc;
		apply_reset();
		cur_k[0] = row.k0;
		cur_k[1] = row.k1;
		cur_latency = row.latency;
		// Both groups step once per cycle until each reaches its own count
		for (int i = 0; i < row.k0 || i < row.k1; i++)
		begin
			for (int g = 0; g < NUM_DQS_GROUPS; g++)
			begin
				inc[g] = (i < cur_k[g]);
			end
			run_cycle(1'b0, inc, '0, 1'b0);
		end
		track_reads = !row.underflow;
		if (row.underflow)
		begin
			uf_state = UF_ANY;
		end
		issue_reads(row.num_reads, row.gap);
		if (row.underflow)
		begin
			if (read_underflow !== 1'b1)
			begin
				value_errors++;
				$display("mismatch read_underflow_o: got 0x%h, expected 0x1", read_underflow);
			end
			// Clearing both FIFOs and retuning L must leave the flag set
			uf_state = UF_HIGH;
			run_cycle(1'b0, '0, '1, 1'b0);
			cur_latency = RECOVERY_LATENCY;
			run_cycle(1'b0, '0, '0, 1'b0);
			track_reads = 1'b1;
			issue_reads(2, 1);
		end
	endtask

	initial
	begin
		int assert_errors;
		void'($urandom(1));
		reset_req = 1'b0;
		rdata_en = 1'b0;
		seq_ctrl = '0;
		ddio_dq = '0;
		cur_k[0] = 0;
		cur_k[1] = 0;
		cur_latency = 2;
		uf_state = UF_ANY;
		track_reads = 1'b0;
		timeout_cycles = 0;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			timeout_cycles += 10 + TEST_TABLE[r].num_reads * TEST_TABLE[r].gap
				+ TEST_TABLE[r].latency + 20;
		end
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			run_row(TEST_TABLE[r]);
		end
		// A reset after the underflow row brings the sticky flag back down
		apply_reset();
		run_cycle(1'b0, '0, '0, 1'b0);
		assert_errors = u_dut.u_checker.assert_failures;
		$display("errors: %0d value mismatches, %0d missing or unexpected valids, %0d %s",
			value_errors, event_errors, assert_errors, "assertion failures");
		if (value_errors == 0 && event_errors == 0 && assert_errors == 0)
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
